/* source/soc_bus_pkg.sv */
// Peripheral bus definitions
// Word, address and select widths, operation codes and the request and response records
package soc_bus_pkg;

	// One bus word
	typedef logic [31:0] data_t;

	// Word address, not byte address
	typedef logic [15:0] addr_t;

	// Byte selects of one word
	typedef logic [3:0] sel_t;

	// Read-write is a swap: old word returned, new word stored
	typedef enum logic [1:0] {
		OP_IDLE  = 2'b00,
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10,
		OP_RDWR  = 2'b11
	} bus_op_e;

	// Held by the master until it sees rdy
	typedef struct packed {
		bus_op_e op;
		addr_t   addr;
		data_t   data;
		sel_t    sel;
	} bus_req_t;

	// Read data is only meaningful while rdy is high
	typedef struct packed {
		data_t data;
		logic  rdy;
	} bus_rsp_t;

endpackage

/* source/soc_map_pkg.sv */
// Address map of the peripheral bus
// Target indices, windows, device descriptions and register offsets
package soc_map_pkg;

	typedef enum logic [2:0] {TGT_RAM, TGT_DEVTBL, TGT_GPIO, TGT_DMA, TGT_INVALID} tgt_e;
	localparam int TGT_COUNT = 5;

	// Windows in words
	localparam soc_bus_pkg::addr_t RAM_BASE    = 16'h0000;
	localparam int                 RAM_WORDS   = 1024;
	localparam soc_bus_pkg::addr_t DEVTBL_BASE = 16'h0400;
	localparam int                 DEVTBL_WORDS = 16;
	localparam soc_bus_pkg::addr_t GPIO_BASE   = 16'h0410;
	localparam int                 GPIO_WORDS  = 4;
	localparam soc_bus_pkg::addr_t DMA_BASE    = 16'h0420;
	localparam int                 DMA_WORDS   = 4;
	localparam int                 INVALID_WORDS = 1024;

	// Device table contents, indexed by tgt_e
	localparam logic [7:0]  TGT_ID      [TGT_COUNT] = '{8'd1, 8'd7, 8'd6, 8'd2, 8'd0};
	localparam logic        TGT_USEINTR [TGT_COUNT] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
	localparam logic [15:0] TGT_MAPSZ   [TGT_COUNT] = '{16'(RAM_WORDS), 16'(DEVTBL_WORDS),
		16'(GPIO_WORDS), 16'(DMA_WORDS), 16'(INVALID_WORDS)};

	// Software reset register inside the device table
	localparam int DEVTBL_RST_OFS = 15;

	// DMA register window
	localparam int DMA_SRC_OFS    = 0;
	localparam int DMA_DST_OFS    = 1;
	localparam int DMA_COUNT_OFS  = 2;
	localparam int DMA_STATUS_OFS = 3;

endpackage

/* source/reset_ctrl.sv */
// System reset controller
// Stretches external and warm resets with a down-counter, latches the power-off request
`timescale 1ns/10ps

module reset_ctrl #(
	parameter int RST_CNTR_BITS = 16
) (
	input  logic clk100mhz_i,
	input  logic rst_p,
	input  logic warm_rst_i,
	input  logic pwroff_i,
	output logic sys_rst_o,
	output logic sys_ready_o
);

	logic [RST_CNTR_BITS-1:0] rst_cntr;
	logic                     pwroff_q;

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || warm_rst_i)
			rst_cntr <= '1;
		else if (|rst_cntr)
			rst_cntr <= rst_cntr - 1'b1;
	end

	// Only the external reset releases power-off
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p)
			pwroff_q <= 1'b0;
		else if (pwroff_i)
			pwroff_q <= 1'b1;
	end

	assign sys_rst_o   = (|rst_cntr) || pwroff_q;
	assign sys_ready_o = !sys_rst_o;

endmodule

/* source/scratch_ram.sv */
// Scratch RAM
// Word memory with byte-select writes and swap, answers one cycle after the request
`timescale 1ns/10ps

module scratch_ram #(
	parameter int RAM_WORDS = 1024
) (
	input  logic                  clk100mhz_i,
	input  soc_bus_pkg::bus_req_t req_i,
	output soc_bus_pkg::bus_rsp_t rsp_o
);

	localparam int AW = $clog2(RAM_WORDS);

	soc_bus_pkg::data_t mem [RAM_WORDS];
	soc_bus_pkg::data_t rd_q;
	logic               rdy_q;
	logic               act;
	logic [AW-1:0]      idx;

	assign act = (req_i.op != soc_bus_pkg::OP_IDLE) && !rdy_q;
	assign idx = req_i.addr[AW-1:0];

	// Old word is captured before the write, which gives swap for free
	always_ff @(posedge clk100mhz_i) begin
		rdy_q <= act;
		if (act) begin
			rd_q <= mem[idx];
			if (req_i.op == soc_bus_pkg::OP_WRITE || req_i.op == soc_bus_pkg::OP_RDWR) begin
				for (int b = 0; b < 4; b++) begin
					if (req_i.sel[b])
						mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
				end
			end
		end
	end

	assign rsp_o = '{data: rd_q, rdy: rdy_q};

endmodule

/* source/device_table.sv */
// Device table
// Read-only description of every bus target, plus the software reset register
`timescale 1ns/10ps

module device_table (
	input  logic                  clk100mhz_i,
	input  logic                  sys_rst_i,
	input  soc_bus_pkg::bus_req_t req_i,
	output soc_bus_pkg::bus_rsp_t rsp_o,
	output logic                  warm_rst_o,
	output logic                  pwroff_o
);

	logic [1:0]         rst_reg;
	logic               rdy_q;
	logic               act;
	soc_bus_pkg::data_t rd_data;
	soc_bus_pkg::data_t data_q;

	assign act = (req_i.op != soc_bus_pkg::OP_IDLE) && !rdy_q;

	// Map size in 31:16, interrupt use in 8, id in 7:0
	always_comb begin
		rd_data = '0;
		if (req_i.addr < soc_map_pkg::TGT_COUNT)
			rd_data = {soc_map_pkg::TGT_MAPSZ[req_i.addr[2:0]], 7'b0,
				soc_map_pkg::TGT_USEINTR[req_i.addr[2:0]], soc_map_pkg::TGT_ID[req_i.addr[2:0]]};
		else if (req_i.addr == soc_map_pkg::DEVTBL_RST_OFS)
			rd_data = {30'b0, rst_reg};
	end

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			rdy_q   <= 1'b0;
			rst_reg <= 2'b00;
		end else begin
			rdy_q <= act;
			if (act && req_i.op != soc_bus_pkg::OP_READ && req_i.sel[0] &&
				req_i.addr == soc_map_pkg::DEVTBL_RST_OFS)
				rst_reg <= req_i.data[1:0];
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (act)
			data_q <= rd_data;
	end

	assign rsp_o = '{data: data_q, rdy: rdy_q};

	// Both bits set is the old cold reset, which does nothing here
	assign warm_rst_o = rst_reg == 2'b10;
	assign pwroff_o   = rst_reg == 2'b01;

endmodule

/* source/gpio_port.sv */
// General-purpose I/O port
// Word 0 is the output register, word 1 reads the synchronised input pins
`timescale 1ns/10ps

module gpio_port #(
	parameter int GPIO_COUNT = 8
) (
	input  logic                  clk100mhz_i,
	input  logic                  sys_rst_i,
	input  soc_bus_pkg::bus_req_t req_i,
	output soc_bus_pkg::bus_rsp_t rsp_o,
	input  logic [GPIO_COUNT-1:0] gpio_i,
	output logic [GPIO_COUNT-1:0] gpio_o
);

	logic [GPIO_COUNT-1:0] out_q;
	logic [GPIO_COUNT-1:0] sync1_q;
	logic [GPIO_COUNT-1:0] sync2_q;
	logic                  rdy_q;
	logic                  act;
	soc_bus_pkg::data_t    data_q;

	assign act = (req_i.op != soc_bus_pkg::OP_IDLE) && !rdy_q;

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
			out_q <= '0;
		end else begin
			rdy_q <= act;
			if (act && req_i.op != soc_bus_pkg::OP_READ && req_i.addr == 16'd0) begin
				for (int i = 0; i < GPIO_COUNT; i++) begin
					if (req_i.sel[i/8])
						out_q[i] <= req_i.data[i];
				end
			end
		end
	end

	// Two-stage synchroniser for the asynchronous pins
	always_ff @(posedge clk100mhz_i) begin
		sync1_q <= gpio_i;
		sync2_q <= sync1_q;
		if (act)
			data_q <= (req_i.addr == 16'd0) ? soc_bus_pkg::data_t'(out_q) :
				(req_i.addr == 16'd1) ? soc_bus_pkg::data_t'(sync2_q) : '0;
	end

	assign rsp_o  = '{data: data_q, rdy: rdy_q};
	assign gpio_o = out_q;

endmodule

/* source/dma_engine.sv */
// Single-channel DMA engine
// Copies COUNT words from SRC to DST over the bus, one read then one write per word
`timescale 1ns/10ps

module dma_engine (
	input  logic                  clk100mhz_i,
	input  logic                  sys_rst_i,
	input  soc_bus_pkg::bus_req_t s_req_i,
	output soc_bus_pkg::bus_rsp_t s_rsp_o,
	output soc_bus_pkg::bus_req_t m_req_o,
	input  soc_bus_pkg::bus_rsp_t m_rsp_i,
	output logic                  dma_irq_o
);

	typedef enum logic [1:0] {DMA_IDLE, DMA_READ, DMA_WRITE} dma_state_e;

	dma_state_e         state;
	soc_bus_pkg::addr_t src_q;
	soc_bus_pkg::addr_t dst_q;
	soc_bus_pkg::addr_t count_q;
	soc_bus_pkg::data_t buf_q;
	soc_bus_pkg::data_t s_data_q;
	soc_bus_pkg::data_t s_rd_data;
	logic               s_rdy_q;
	logic               done_q;
	logic               busy;
	logic               s_act;
	logic               s_wr;

	assign busy  = state != DMA_IDLE;
	assign s_act = (s_req_i.op != soc_bus_pkg::OP_IDLE) && !s_rdy_q;
	assign s_wr  = s_act && (s_req_i.op != soc_bus_pkg::OP_READ);

	always_comb begin
		case (s_req_i.addr)
			soc_map_pkg::DMA_SRC_OFS:    s_rd_data = {16'b0, src_q};
			soc_map_pkg::DMA_DST_OFS:    s_rd_data = {16'b0, dst_q};
			soc_map_pkg::DMA_COUNT_OFS:  s_rd_data = {16'b0, count_q};
			soc_map_pkg::DMA_STATUS_OFS: s_rd_data = {30'b0, done_q, busy};
			default:                     s_rd_data = '0;
		endcase
	end

	// Master request follows the state directly
	always_comb begin
		m_req_o.op   = soc_bus_pkg::OP_IDLE;
		m_req_o.addr = src_q;
		m_req_o.data = buf_q;
		m_req_o.sel  = '1;
		if (state == DMA_READ) begin
			m_req_o.op = soc_bus_pkg::OP_READ;
		end else if (state == DMA_WRITE) begin
			m_req_o.op   = soc_bus_pkg::OP_WRITE;
			m_req_o.addr = dst_q;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			state   <= DMA_IDLE;
			count_q <= '0;
			done_q  <= 1'b0;
			s_rdy_q <= 1'b0;
		end else begin
			s_rdy_q <= s_act;
			if (s_wr) begin
				if (s_req_i.addr == soc_map_pkg::DMA_STATUS_OFS)
					done_q <= 1'b0;
				if (!busy && s_req_i.addr == soc_map_pkg::DMA_SRC_OFS)
					src_q <= s_req_i.data[15:0];
				if (!busy && s_req_i.addr == soc_map_pkg::DMA_DST_OFS)
					dst_q <= s_req_i.data[15:0];
				if (!busy && s_req_i.addr == soc_map_pkg::DMA_COUNT_OFS) begin
					count_q <= s_req_i.data[15:0];
					if (|s_req_i.data[15:0])
						state <= DMA_READ;
				end
			end
			// Completion comes last so it wins over a STATUS write
			if (state == DMA_READ && m_rsp_i.rdy) begin
				buf_q <= m_rsp_i.data;
				state <= DMA_WRITE;
			end else if (state == DMA_WRITE && m_rsp_i.rdy) begin
				src_q   <= src_q + 1'b1;
				dst_q   <= dst_q + 1'b1;
				count_q <= count_q - 1'b1;
				if (count_q == 16'd1) begin
					state  <= DMA_IDLE;
					done_q <= 1'b1;
				end else begin
					state <= DMA_READ;
				end
			end
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (s_act)
			s_data_q <= s_rd_data;
	end

	assign s_rsp_o   = '{data: s_data_q, rdy: s_rdy_q};
	assign dma_irq_o = done_q;

endmodule

/* source/bus_arbiter.sv */
// Fixed-priority bus arbiter with address decoder
// Host wins over DMA; the owner keeps the bus until its rdy, unmapped words read zero
`timescale 1ns/10ps

module bus_arbiter (
	input  logic                  clk100mhz_i,
	input  logic                  rst_p,
	input  soc_bus_pkg::bus_req_t host_req_i,
	input  soc_bus_pkg::bus_req_t dma_req_i,
	output soc_bus_pkg::bus_rsp_t host_rsp_o,
	output soc_bus_pkg::bus_rsp_t dma_rsp_o,
	output soc_bus_pkg::bus_req_t tgt_req_o [soc_map_pkg::TGT_COUNT],
	input  soc_bus_pkg::bus_rsp_t tgt_rsp_i [soc_map_pkg::TGT_COUNT]
);

	logic                  gnt_valid;
	logic                  gnt_dma;
	soc_bus_pkg::bus_req_t gnt_req;
	soc_map_pkg::tgt_e     tgt_sel;
	soc_bus_pkg::addr_t    tgt_base;
	soc_bus_pkg::bus_rsp_t sel_rsp;

	// Offset wraps for addresses below base, so one compare covers both ends
	function automatic logic in_window(soc_bus_pkg::addr_t addr, soc_bus_pkg::addr_t base,
		int words);
		soc_bus_pkg::addr_t ofs;
		ofs = addr - base;
		return int'(ofs) < words;
	endfunction

	assign gnt_req = gnt_dma ? dma_req_i : host_req_i;

	always_comb begin
		tgt_sel  = soc_map_pkg::TGT_INVALID;
		tgt_base = '0;
		if (in_window(gnt_req.addr, soc_map_pkg::RAM_BASE, soc_map_pkg::RAM_WORDS)) begin
			tgt_sel  = soc_map_pkg::TGT_RAM;
			tgt_base = soc_map_pkg::RAM_BASE;
		end else if (in_window(gnt_req.addr, soc_map_pkg::DEVTBL_BASE,
			soc_map_pkg::DEVTBL_WORDS)) begin
			tgt_sel  = soc_map_pkg::TGT_DEVTBL;
			tgt_base = soc_map_pkg::DEVTBL_BASE;
		end else if (in_window(gnt_req.addr, soc_map_pkg::GPIO_BASE,
			soc_map_pkg::GPIO_WORDS)) begin
			tgt_sel  = soc_map_pkg::TGT_GPIO;
			tgt_base = soc_map_pkg::GPIO_BASE;
		end else if (in_window(gnt_req.addr, soc_map_pkg::DMA_BASE,
			soc_map_pkg::DMA_WORDS)) begin
			tgt_sel  = soc_map_pkg::TGT_DMA;
			tgt_base = soc_map_pkg::DMA_BASE;
		end
	end

	// Only the selected target sees a live op
	always_comb begin
		for (int i = 0; i < soc_map_pkg::TGT_COUNT; i++) begin
			tgt_req_o[i] = '0;
		end
		if (gnt_valid) begin
			tgt_req_o[tgt_sel]      = gnt_req;
			tgt_req_o[tgt_sel].addr = gnt_req.addr - tgt_base;
		end
	end

	// Default target answers in the same cycle with zero
	always_comb begin
		sel_rsp = tgt_rsp_i[tgt_sel];
		if (tgt_sel == soc_map_pkg::TGT_INVALID) begin
			sel_rsp.data = '0;
			sel_rsp.rdy  = tgt_req_o[soc_map_pkg::TGT_INVALID].op != soc_bus_pkg::OP_IDLE;
		end
	end

	always_comb begin
		host_rsp_o = '0;
		dma_rsp_o  = '0;
		if (gnt_valid) begin
			if (gnt_dma)
				dma_rsp_o = sel_rsp;
			else
				host_rsp_o = sel_rsp;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			gnt_valid <= 1'b0;
			gnt_dma   <= 1'b0;
		end else if (!gnt_valid) begin
			if (host_req_i.op != soc_bus_pkg::OP_IDLE) begin
				gnt_valid <= 1'b1;
				gnt_dma   <= 1'b0;
			end else if (dma_req_i.op != soc_bus_pkg::OP_IDLE) begin
				gnt_valid <= 1'b1;
				gnt_dma   <= 1'b1;
			end
		end else if (sel_rsp.rdy) begin
			// Decision for the next owner is taken in the following cycle
			gnt_valid <= 1'b0;
		end
	end

endmodule

/* source/soc_top.sv */
// System top level
// Host port and DMA share the peripheral bus to RAM, device table, GPIO and DMA registers
`timescale 1ns/10ps

module soc_top #(
	parameter int RST_CNTR_BITS = 16,
	parameter int GPIO_COUNT    = 8
) (
	input  logic                  clk100mhz_i,
	input  logic                  rst_p,
	input  soc_bus_pkg::bus_req_t host_req_i,
	output soc_bus_pkg::bus_rsp_t host_rsp_o,
	input  logic [GPIO_COUNT-1:0] gpio_i,
	output logic [GPIO_COUNT-1:0] gpio_o,
	output logic                  dma_irq_o,
	output logic                  sys_ready_o
);

	logic                  sys_rst;
	logic                  warm_rst;
	logic                  pwroff;
	soc_bus_pkg::bus_req_t dma_m_req;
	soc_bus_pkg::bus_rsp_t dma_m_rsp;
	soc_bus_pkg::bus_req_t tgt_req [soc_map_pkg::TGT_COUNT];
	soc_bus_pkg::bus_rsp_t tgt_rsp [soc_map_pkg::TGT_COUNT];

	reset_ctrl #(.RST_CNTR_BITS(RST_CNTR_BITS)) rstc0 (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.warm_rst_i  (warm_rst),
		.pwroff_i    (pwroff),
		.sys_rst_o   (sys_rst),
		.sys_ready_o (sys_ready_o)
	);

	// Arbiter follows the system reset so a warm reset drops any grant
	bus_arbiter arb0 (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (sys_rst),
		.host_req_i  (host_req_i),
		.dma_req_i   (dma_m_req),
		.host_rsp_o  (host_rsp_o),
		.dma_rsp_o   (dma_m_rsp),
		.tgt_req_o   (tgt_req),
		.tgt_rsp_i   (tgt_rsp)
	);

	// Default target lives inside the arbiter
	assign tgt_rsp[soc_map_pkg::TGT_INVALID] = '0;

	scratch_ram #(.RAM_WORDS(soc_map_pkg::RAM_WORDS)) ram0 (
		.clk100mhz_i (clk100mhz_i),
		.req_i       (tgt_req[soc_map_pkg::TGT_RAM]),
		.rsp_o       (tgt_rsp[soc_map_pkg::TGT_RAM])
	);

	device_table devtbl0 (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst),
		.req_i       (tgt_req[soc_map_pkg::TGT_DEVTBL]),
		.rsp_o       (tgt_rsp[soc_map_pkg::TGT_DEVTBL]),
		.warm_rst_o  (warm_rst),
		.pwroff_o    (pwroff)
	);

	gpio_port #(.GPIO_COUNT(GPIO_COUNT)) gpio0 (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst),
		.req_i       (tgt_req[soc_map_pkg::TGT_GPIO]),
		.rsp_o       (tgt_rsp[soc_map_pkg::TGT_GPIO]),
		.gpio_i      (gpio_i),
		.gpio_o      (gpio_o)
	);

	dma_engine dma0 (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst),
		.s_req_i     (tgt_req[soc_map_pkg::TGT_DMA]),
		.s_rsp_o     (tgt_rsp[soc_map_pkg::TGT_DMA]),
		.m_req_o     (dma_m_req),
		.m_rsp_i     (dma_m_rsp),
		.dma_irq_o   (dma_irq_o)
	);

endmodule

/* testbench/tb_soc.sv */
// Testbench for the peripheral bus system
// Random host traffic checked against RAM, GPIO and address map models
`timescale 1ns/10ps

module tb_soc;

	localparam int RST_BITS   = 4;
	localparam int GPIO_COUNT = 8;
	localparam int RAM_WORDS  = 1024;
	localparam int RAND_OPS   = 400;
	localparam int OP_COUNT   = RAM_WORDS + RAND_OPS + 300;
	localparam int RDY_LIMIT  = 100;
	localparam int LOW_LIMIT  = 200;

	// First word past the DMA window, nothing is mapped from here up
	localparam soc_bus_pkg::addr_t UNMAPPED_BASE =
		soc_map_pkg::DMA_BASE + 16'(soc_map_pkg::DMA_WORDS);

	logic                  clk100mhz_i;
	logic                  rst_p;
	soc_bus_pkg::bus_req_t host_req;
	soc_bus_pkg::bus_rsp_t host_rsp;
	logic [GPIO_COUNT-1:0] gpio_in;
	logic [GPIO_COUNT-1:0] gpio_out;
	logic                  dma_irq;
	logic                  sys_ready;

	int                    seed;
	int                    errors;
	int                    checks;
	soc_bus_pkg::data_t    ram_model [RAM_WORDS];
	logic [GPIO_COUNT-1:0] gpio_model;

	soc_top #(
		.RST_CNTR_BITS (RST_BITS),
		.GPIO_COUNT    (GPIO_COUNT)
	) dut0 (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.host_req_i  (host_req),
		.host_rsp_o  (host_rsp),
		.gpio_i      (gpio_in),
		.gpio_o      (gpio_out),
		.dma_irq_o   (dma_irq),
		.sys_ready_o (sys_ready)
	);

	initial begin
		clk100mhz_i = 1'b0;
		forever #5 clk100mhz_i = ~clk100mhz_i;
	end

	initial begin
		repeat (OP_COUNT * 40) @(posedge clk100mhz_i);
		$display("Watchdog expired after %0d cycles, the tests did not finish", OP_COUNT * 40);
		$display("TESTBENCH FAILED");
		$finish;
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic soc_bus_pkg::data_t merge_bytes(input soc_bus_pkg::data_t old_word,
		input soc_bus_pkg::data_t new_word, input soc_bus_pkg::sel_t sel);
		soc_bus_pkg::data_t res;
		res = old_word;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		end
		return res;
	endfunction

	// Descriptor per target: map size, interrupt use, id
	function automatic soc_bus_pkg::data_t expected_entry(input int i);
		case (i)
			0:       return {16'd1024, 7'b0, 1'b0, 8'd1};
			1:       return {16'd16, 7'b0, 1'b0, 8'd7};
			2:       return {16'd4, 7'b0, 1'b1, 8'd6};
			3:       return {16'd4, 7'b0, 1'b1, 8'd2};
			4:       return {16'd1024, 7'b0, 1'b0, 8'd0};
			default: return 32'h0;
		endcase
	endfunction

	// One host transaction, held until rdy and then dropped to idle
	task automatic bus_transfer(input soc_bus_pkg::bus_op_e op, input soc_bus_pkg::addr_t addr,
		input soc_bus_pkg::data_t wdata, input soc_bus_pkg::sel_t sel,
		output soc_bus_pkg::data_t rdata);
		int   waited;
		logic seen;
		waited = 0;
		seen   = 1'b0;
		rdata  = '0;
		@(negedge clk100mhz_i);
		host_req.op   = op;
		host_req.addr = addr;
		host_req.data = wdata;
		host_req.sel  = sel;
		while (!seen && waited < RDY_LIMIT) begin
			@(negedge clk100mhz_i);
			waited++;
			if (host_rsp.rdy) begin
				seen  = 1'b1;
				rdata = host_rsp.data;
			end
		end
		if (!seen) begin
			errors++;
			$display("Host request to address %h got no rdy within %0d cycles", addr, RDY_LIMIT);
		end
		@(negedge clk100mhz_i);
		host_req.op = soc_bus_pkg::OP_IDLE;
	endtask

	task automatic write_word(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t data,
		input soc_bus_pkg::sel_t sel);
		soc_bus_pkg::data_t unused;
		bus_transfer(soc_bus_pkg::OP_WRITE, addr, data, sel, unused);
	endtask

	task automatic read_word(input soc_bus_pkg::addr_t addr, output soc_bus_pkg::data_t data);
		bus_transfer(soc_bus_pkg::OP_READ, addr, 32'h0, 4'hf, data);
	endtask

	task automatic apply_reset();
		rst_p = 1'b1;
		repeat (3) @(posedge clk100mhz_i);
		@(negedge clk100mhz_i);
		rst_p = 1'b0;
	endtask

	// Counts falling edges with sys_ready_o low, starting at the current one
	task automatic count_low_cycles(input logic check_idle, output int n);
		n = 0;
		while (!sys_ready && n < LOW_LIMIT) begin
			if (check_idle) begin
				check_value(32'(dma_irq), 32'h0, "dma_irq_o while held in reset");
				check_value(32'(gpio_out), 32'h0, "gpio_o while held in reset");
			end
			n++;
			@(negedge clk100mhz_i);
		end
		if (n == LOW_LIMIT) begin
			errors++;
			$display("sys_ready_o stayed low for more than %0d cycles", LOW_LIMIT);
		end
	endtask

	task automatic test_ram();
		soc_bus_pkg::data_t rdata;
		soc_bus_pkg::data_t wdata;
		soc_bus_pkg::sel_t  sel;
		int                 idx;
		int                 kind;
		// Fill pattern mixes every address bit into both halves
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram_model[i] = {16'(i) ^ 16'hc3a5, ~16'(i)};
			write_word(16'(i), ram_model[i], 4'hf);
		end
		for (int k = 0; k < RAND_OPS; k++) begin
			idx   = rand_below(RAM_WORDS);
			kind  = rand_below(3);
			wdata = $random(seed);
			sel   = 4'($random(seed));
			case (kind)
				0: begin
					write_word(16'(idx), wdata, sel);
					ram_model[idx] = merge_bytes(ram_model[idx], wdata, sel);
				end
				1: begin
					read_word(16'(idx), rdata);
					check_value(rdata, ram_model[idx], $sformatf("RAM read of word %0d", idx));
				end
				default: begin
					bus_transfer(soc_bus_pkg::OP_RDWR, 16'(idx), wdata, sel, rdata);
					check_value(rdata, ram_model[idx], $sformatf("RAM swap of word %0d", idx));
					ram_model[idx] = merge_bytes(ram_model[idx], wdata, sel);
				end
			endcase
		end
	endtask

	task automatic test_map();
		soc_bus_pkg::data_t rdata;
		soc_bus_pkg::addr_t addr;
		for (int i = 0; i < soc_map_pkg::DEVTBL_WORDS; i++) begin
			read_word(soc_map_pkg::DEVTBL_BASE + 16'(i), rdata);
			check_value(rdata, expected_entry(i), $sformatf("device table word %0d", i));
		end
		for (int k = 0; k < 8; k++) begin
			addr = UNMAPPED_BASE;
			if (k > 0)
				addr = UNMAPPED_BASE + 16'(rand_below(65536 - int'(UNMAPPED_BASE)));
			read_word(addr, rdata);
			check_value(rdata, 32'h0, $sformatf("unmapped address %h", addr));
		end
	endtask

	task automatic test_gpio();
		soc_bus_pkg::data_t    rdata;
		soc_bus_pkg::data_t    wdata;
		soc_bus_pkg::sel_t     sel;
		logic [GPIO_COUNT-1:0] pins;
		int                    polls;
		gpio_model = '0;
		for (int k = 0; k < 8; k++) begin
			wdata = $random(seed);
			sel   = 4'($random(seed));
			write_word(soc_map_pkg::GPIO_BASE, wdata, sel);
			// Eight pins sit in byte 0
			if (sel[0])
				gpio_model = wdata[GPIO_COUNT-1:0];
			check_value(32'(gpio_out), 32'(gpio_model), "gpio_o after output write");
			read_word(soc_map_pkg::GPIO_BASE, rdata);
			check_value(rdata, 32'(gpio_model), "GPIO output register readback");
		end
		for (int k = 0; k < 8; k++) begin
			pins = GPIO_COUNT'($random(seed));
			@(negedge clk100mhz_i);
			gpio_in = pins;
			read_word(soc_map_pkg::GPIO_BASE + 16'd1, rdata);
			polls = 1;
			while (rdata !== 32'(pins) && polls < 4) begin
				read_word(soc_map_pkg::GPIO_BASE + 16'd1, rdata);
				polls++;
			end
			check_value(rdata, 32'(pins), "GPIO input pins after sync delay");
		end
	endtask

	task automatic test_dma();
		soc_bus_pkg::data_t rdata;
		int                 src;
		int                 dst;
		int                 len;
		int                 idx;
		int                 polls;
		len = 1 + rand_below(16);
		src = rand_below(512 - len);
		dst = 512 + rand_below(512 - len);
		write_word(soc_map_pkg::DMA_BASE + 16'(soc_map_pkg::DMA_SRC_OFS), 32'(src), 4'hf);
		write_word(soc_map_pkg::DMA_BASE + 16'(soc_map_pkg::DMA_DST_OFS), 32'(dst), 4'hf);
		write_word(soc_map_pkg::DMA_BASE + 16'(soc_map_pkg::DMA_COUNT_OFS), 32'(len), 4'hf);
		// Host reads in the lower half compete with the copy
		polls = 0;
		while (!dma_irq && polls < 200) begin
			idx = rand_below(512);
			read_word(16'(idx), rdata);
			check_value(rdata, ram_model[idx], $sformatf("RAM word %0d read during DMA", idx));
			polls++;
		end
		if (!dma_irq) begin
			errors++;
			$display("DMA copy of %0d words from %0d to %0d never raised dma_irq_o",
				len, src, dst);
		end
		for (int i = 0; i < len; i++) begin
			ram_model[dst + i] = ram_model[src + i];
		end
		for (int i = 0; i < len; i++) begin
			read_word(16'(dst + i), rdata);
			check_value(rdata, ram_model[dst + i], $sformatf("DMA destination word %0d", dst + i));
		end
		read_word(soc_map_pkg::DMA_BASE + 16'(soc_map_pkg::DMA_STATUS_OFS), rdata);
		check_value(rdata, 32'h2, "DMA STATUS after copy");
		write_word(soc_map_pkg::DMA_BASE + 16'(soc_map_pkg::DMA_STATUS_OFS), 32'h0, 4'hf);
		check_value(32'(dma_irq), 32'h0, "dma_irq_o after STATUS write");
		read_word(soc_map_pkg::DMA_BASE + 16'(soc_map_pkg::DMA_STATUS_OFS), rdata);
		check_value(rdata, 32'h0, "DMA STATUS after clear");
	endtask

	task automatic test_resets();
		soc_bus_pkg::data_t rdata;
		int                 n;
		int                 idx;
		write_word(soc_map_pkg::DEVTBL_BASE + 16'(soc_map_pkg::DEVTBL_RST_OFS), 32'h2, 4'hf);
		check_value(32'(sys_ready), 32'h0, "sys_ready_o after warm reset request");
		count_low_cycles(1'b0, n);
		// Request bit keeps reloading the counter until the table sees the reset
		check_value(n, 1 << RST_BITS, "cycles held in warm reset");
		for (int k = 0; k < 8; k++) begin
			idx = rand_below(RAM_WORDS);
			read_word(16'(idx), rdata);
			check_value(rdata, ram_model[idx], $sformatf("RAM word %0d after warm reset", idx));
		end
		write_word(soc_map_pkg::DEVTBL_BASE + 16'(soc_map_pkg::DEVTBL_RST_OFS), 32'h1, 4'hf);
		for (int k = 0; k < 40; k++) begin
			check_value(32'(sys_ready), 32'h0, "sys_ready_o while powered off");
			@(negedge clk100mhz_i);
		end
		apply_reset();
		count_low_cycles(1'b1, n);
		check_value(n, (1 << RST_BITS) - 1, "cycles from rst_p release after power-off");
	endtask

	initial begin
		int n;
		seed     = 32'h6cd6;
		errors   = 0;
		checks   = 0;
		host_req = '0;
		gpio_in  = '0;
		rst_p    = 1'b1;
		apply_reset();
		count_low_cycles(1'b1, n);
		check_value(n, (1 << RST_BITS) - 1, "cycles from rst_p release to sys_ready_o");
		test_ram();
		test_map();
		test_gpio();
		test_dma();
		test_resets();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* sources.f */
source/soc_bus_pkg.sv
source/soc_map_pkg.sv
source/reset_ctrl.sv
source/scratch_ram.sv
source/device_table.sv
source/gpio_port.sv
source/dma_engine.sv
source/bus_arbiter.sv
source/soc_top.sv
testbench/tb_soc.sv

/* Bender.yml */
package:
  name: periph_bus_soc

sources:
  - source/soc_bus_pkg.sv
  - source/soc_map_pkg.sv
  - source/reset_ctrl.sv
  - source/scratch_ram.sv
  - source/device_table.sv
  - source/gpio_port.sv
  - source/dma_engine.sv
  - source/bus_arbiter.sv
  - source/soc_top.sv
  - target: simulation
    files:
      - testbench/tb_soc.sv
